// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

   //////////////////////////////
   // Widths and counts
   //////////////////////////////

   localparam int data_w     = 16;   // Data word width
   localparam int reg_addr_w = 4;    // Register index width
   localparam int num_regs   = 16;   // Register file depth

   //////////////////////////////
   // Types
   //////////////////////////////

   typedef logic [data_w-1:0]     word_t;       // Data word
   typedef logic [reg_addr_w-1:0] reg_addr_t;   // Register index
   typedef logic [3:0]            opcode_t;     // Major opcode or sub-opcode
   typedef logic [7:0]            imm_t;        // Raw immediate field
   typedef logic [2:0]            alu_op_t;     // ALU operation select

   // Carry, overflow, negative and zero from the top bit down
   typedef logic [3:0]            flags_t;

   //////////////////////////////
   // ALU operation codes
   //////////////////////////////

   localparam alu_op_t alu_add = 3'b000;   // A plus B
   localparam alu_op_t alu_sub = 3'b001;   // A minus B
   localparam alu_op_t alu_and = 3'b010;   // Bitwise and
   localparam alu_op_t alu_or  = 3'b011;   // Bitwise or
   localparam alu_op_t alu_xor = 3'b100;   // Bitwise xor
   localparam alu_op_t alu_cmp = 3'b110;   // Difference, flags only

   //////////////////////////////
   // Opcodes
   //////////////////////////////

   // Sub-opcodes of the register form reuse these values
   localparam opcode_t op_rr   = 4'b0000;   // Register-register group
   localparam opcode_t op_addi = 4'b0101;   // Add
   localparam opcode_t op_subi = 4'b1001;   // Subtract
   localparam opcode_t op_cmpi = 4'b1011;   // Compare
   localparam opcode_t op_andi = 4'b0001;   // And
   localparam opcode_t op_ori  = 4'b0010;   // Or
   localparam opcode_t op_xori = 4'b0011;   // Xor

endpackage

// ==== verilog/datapath_if.sv ====
`timescale 1ns/1ps

interface datapath_if;

   //////////////////////////////
   // Decoder side
   //////////////////////////////

   cpu_pkg::reg_addr_t dest_addr;   // Rdest, read and written
   cpu_pkg::reg_addr_t src_addr;    // Rsrc, read only
   cpu_pkg::alu_op_t   alu_op;      // Operation select
   logic               use_imm;     // High for immediate forms
   cpu_pkg::word_t     imm;         // Sign-extended immediate
   logic               wr_en;       // Write result back to Rdest

   //////////////////////////////
   // Register file and ALU side
   //////////////////////////////

   cpu_pkg::word_t     dest_data;   // Rdest contents, operand A
   cpu_pkg::word_t     src_data;    // Rsrc contents
   cpu_pkg::word_t     result;      // ALU output, write data

   // Decoder drives the control fields
   modport producer (output dest_addr, src_addr, alu_op, use_imm, imm, wr_en);

   // Register file serves reads and takes the write
   modport buffer (input dest_addr, src_addr, wr_en, result,
                   output dest_data, src_data);

   // ALU consumes operands and returns the result
   modport consumer (input alu_op, use_imm, imm, dest_data, src_data,
                     output result);

endinterface

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
(
   input  logic               clk,
   input  logic               reset,
   input  cpu_pkg::word_t     inst,   // Instruction word, sampled every edge
   datapath_if.producer       dp
);

   cpu_pkg::word_t   inst_q;    // Instruction register
   cpu_pkg::opcode_t opcode;    // Bits 15:12
   cpu_pkg::opcode_t sub_op;    // Bits 7:4, register form only
   cpu_pkg::opcode_t code;      // Effective operation code
   cpu_pkg::imm_t    imm_raw;   // Bits 7:0
   cpu_pkg::alu_op_t dec_op;    // Decoded ALU operation
   logic             known;     // Code is one of the six operations

   // Returns {known, alu_op}
   function automatic logic [3:0] map_code(input cpu_pkg::opcode_t c);
      logic [3:0] m;
      case (c)
         cpu_pkg::op_addi: m = {1'b1, cpu_pkg::alu_add};
         cpu_pkg::op_subi: m = {1'b1, cpu_pkg::alu_sub};
         cpu_pkg::op_cmpi: m = {1'b1, cpu_pkg::alu_cmp};
         cpu_pkg::op_andi: m = {1'b1, cpu_pkg::alu_and};
         cpu_pkg::op_ori:  m = {1'b1, cpu_pkg::alu_or};
         cpu_pkg::op_xori: m = {1'b1, cpu_pkg::alu_xor};
         default:          m = {1'b0, cpu_pkg::alu_add};   // Shows A+B, no write
      endcase
      return m;
   endfunction

   //////////////////////////////
   // Instruction register
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
         inst_q <= '0;   // Decodes as unknown reg form
      else
         inst_q <= inst;
   end

   //////////////////////////////
   // Field split and decode
   //////////////////////////////

   assign opcode  = inst_q[15:12];
   assign sub_op  = inst_q[7:4];
   assign imm_raw = inst_q[7:0];

   always_comb
   begin
      // Register form takes its operation from the sub-opcode
      code            = (opcode == cpu_pkg::op_rr) ? sub_op : opcode;
      {known, dec_op} = map_code(code);
   end

   assign dp.dest_addr = inst_q[11:8];
   assign dp.src_addr  = inst_q[3:0];
   assign dp.alu_op    = dec_op;
   assign dp.use_imm   = (opcode != cpu_pkg::op_rr);            // Every other opcode is imm
   assign dp.wr_en     = known && (dec_op != cpu_pkg::alu_cmp); // Compare sets flags only
   assign dp.imm       = {{8{imm_raw[7]}}, imm_raw};           // Sign extend

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
(
   input  logic         clk,
   input  logic         reset,
   datapath_if.buffer   dp
);

   cpu_pkg::word_t regs [cpu_pkg::num_regs];   // Sixteen general registers

   //////////////////////////////
   // Write port
   //////////////////////////////

   // Write lands on the edge that ends the instruction
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < cpu_pkg::num_regs; i++)
         begin
            regs[i] <= '0;   // All registers start at zero
         end
      end
      else if (dp.wr_en)
      begin
         regs[dp.dest_addr] <= dp.result;   // Rdest gets ALU output
      end
   end

   //////////////////////////////
   // Read ports
   //////////////////////////////

   // Both reads are combinational
   assign dp.dest_data = regs[dp.dest_addr];   // Operand A
   assign dp.src_data  = regs[dp.src_addr];    // Operand B in reg form

endmodule

// ==== verilog/carry_select_adder.sv ====
`timescale 1ns/1ps

module carry_select_adder
(
   input  cpu_pkg::word_t a,          // Augend or minuend
   input  cpu_pkg::word_t b,          // Addend or subtrahend
   input  logic           subtract,   // High for a minus b
   output cpu_pkg::word_t sum,        // Sum or difference
   output logic           carry,      // Carry out, no-borrow on subtract
   output logic           overflow    // Signed overflow
);

   cpu_pkg::word_t b_x;               // b, inverted when subtracting
   logic [5:0]     nib_res [4];       // Per nibble {cout, c3, sum}

   // 4-bit ripple adder returning {cout, carry into bit 3, sum}
   function automatic logic [5:0] ripple_nibble(input logic [3:0] x,
                                                input logic [3:0] y,
                                                input logic       cin);
      logic [4:0] c;
      logic [3:0] s;
      c[0] = cin;
      for (int i = 0; i < 4; i++)
      begin
         s[i]   = x[i] ^ y[i] ^ c[i];
         c[i+1] = (x[i] & y[i]) | (x[i] & c[i]) | (y[i] & c[i]);   // Majority
      end
      return {c[4], c[3], s};
   endfunction

   assign b_x = b ^ {cpu_pkg::data_w{subtract}};   // One's complement on subtract

   //////////////////////////////
   // Nibble stages
   //////////////////////////////

   for (genvar n = 0; n < 4; n++)
   begin : g_nib
      if (n == 0)
      begin : g_direct
         // Injected carry completes the two's complement
         assign nib_res[n] = ripple_nibble(a[3:0], b_x[3:0], subtract);
      end
      else
      begin : g_select
         logic [5:0] res_c0;   // Assumes carry in of 0
         logic [5:0] res_c1;   // Assumes carry in of 1
         assign res_c0     = ripple_nibble(a[4*n +: 4], b_x[4*n +: 4], 1'b0);
         assign res_c1     = ripple_nibble(a[4*n +: 4], b_x[4*n +: 4], 1'b1);
         assign nib_res[n] = nib_res[n-1][5] ? res_c1 : res_c0;   // Lower carry picks
      end
      assign sum[4*n +: 4] = nib_res[n][3:0];
   end

   assign carry    = nib_res[3][5];
   assign overflow = nib_res[3][5] ^ nib_res[3][4];   // Carry in vs out of MSB

endmodule

// ==== verilog/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit
(
   datapath_if.consumer    dp,
   output cpu_pkg::flags_t flags   // Carry, overflow, negative, zero
);

   cpu_pkg::word_t operand_b;   // Immediate or Rsrc
   cpu_pkg::word_t as_sum;      // Adder/subtractor output
   cpu_pkg::word_t alu_out;     // Selected result
   logic           as_carry;    // Adder carry out
   logic           as_ovf;      // Adder overflow
   logic           arith;       // Add, sub or cmp in flight

   //////////////////////////////
   // Operands and adder
   //////////////////////////////

   assign operand_b = dp.use_imm ? dp.imm : dp.src_data;

   carry_select_adder addsub_i
   (
      .a        (dp.dest_data),                   // Rdest is always A
      .b        (operand_b),
      .subtract (dp.alu_op != cpu_pkg::alu_add),  // Sub and cmp
      .sum      (as_sum),
      .carry    (as_carry),
      .overflow (as_ovf)
   );

   //////////////////////////////
   // Result select
   //////////////////////////////

   always_comb
   begin
      case (dp.alu_op)
         cpu_pkg::alu_and: alu_out = dp.dest_data & operand_b;
         cpu_pkg::alu_or:  alu_out = dp.dest_data | operand_b;
         cpu_pkg::alu_xor: alu_out = dp.dest_data ^ operand_b;
         default:          alu_out = as_sum;   // Add, sub, cmp difference
      endcase
   end

   assign arith = (dp.alu_op == cpu_pkg::alu_add) ||
                  (dp.alu_op == cpu_pkg::alu_sub) ||
                  (dp.alu_op == cpu_pkg::alu_cmp);

   // Logical ops clear C, V and N
   assign flags = {as_carry & arith,
                   as_ovf & arith,
                   alu_out[cpu_pkg::data_w-1] & arith,
                   alu_out == '0};                      // Zero from any result

   assign dp.result = alu_out;

endmodule

// ==== verilog/cpu_datapath.sv ====
`timescale 1ns/1ps

module cpu_datapath
(
   input  logic            clk,
   input  logic            reset,
   input  cpu_pkg::word_t  inst,     // One instruction per cycle
   output cpu_pkg::word_t  result,   // ALU result of the current instruction
   output cpu_pkg::flags_t flags     // Carry, overflow, negative, zero
);

   //////////////////////////////
   // Stage wiring
   //////////////////////////////

   datapath_if dp_if ();   // Decoder, register file and ALU share this

   instr_decoder decoder_i
   (
      .clk   (clk),
      .reset (reset),
      .inst  (inst),
      .dp    (dp_if.producer)
   );

   reg_file reg_file_i
   (
      .clk   (clk),
      .reset (reset),
      .dp    (dp_if.buffer)
   );

   alu_unit alu_i
   (
      .dp    (dp_if.consumer),
      .flags (flags)
   );

   assign result = dp_if.result;   // Same word the register file writes

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
   output logic clk,
   output logic reset
);

   localparam int half_period_ns = 20;   // 40 ns clock

   initial
   begin
      clk = 1'b0;
      forever
         #(half_period_ns) clk = ~clk;
   end

   // Held over two rising edges, dropped on a falling edge
   initial
   begin
      reset = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

// ==== verif/cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker
(
   input  logic            clk,
   input  logic            reset,
   input  cpu_pkg::word_t  inst,     // Same word the DUT samples
   input  cpu_pkg::word_t  result,
   input  cpu_pkg::flags_t flags,
   output int              checks,   // Comparisons made so far
   output int              errors    // Comparisons that went wrong
);

   string          test_name = "none";   // Set by the testbench per test
   cpu_pkg::word_t model_regs [16];      // Expected register contents
   cpu_pkg::word_t cap_inst;             // Word taken at the last rising edge
   logic           cap_reset;            // Reset seen at that edge
   logic           cap_valid = 1'b0;     // No edge seen yet
   int             n_checks = 0;
   int             n_errors = 0;

   assign checks = n_checks;
   assign errors = n_errors;

   task automatic compare(input string what, input logic [15:0] exp, input logic [15:0] act);
      n_checks++;
      if (act !== exp)
      begin
         n_errors++;
         $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   //////////////////////////////
   // Capture at the rising edge
   //////////////////////////////

   always @(posedge clk)
   begin
      cap_inst  <= inst;
      cap_reset <= reset;
      cap_valid <= 1'b1;
   end

   //////////////////////////////
   // Model and compare
   //////////////////////////////

   // Outputs are settled by the falling edge
   always @(negedge clk)
   begin
      cpu_pkg::opcode_t   op;
      cpu_pkg::opcode_t   code;
      cpu_pkg::reg_addr_t rd;
      cpu_pkg::word_t     a;
      cpu_pkg::word_t     b;
      cpu_pkg::word_t     res;
      logic [16:0]        wide;
      logic               c;
      logic               v;
      logic               arith;
      logic               known;
      logic               wr;
      if (cap_valid && cap_reset)
      begin
         foreach (model_regs[i])
            model_regs[i] = '0;
         compare("result", 16'h0000, result);
         compare("flags", 16'h0001, flags);   // Zero only
      end
      else if (cap_valid)
      begin
         op    = cap_inst[15:12];
         code  = (op == cpu_pkg::op_rr) ? cap_inst[7:4] : op;   // Reg form uses sub-op
         rd    = cap_inst[11:8];
         a     = model_regs[rd];
         b     = (op == cpu_pkg::op_rr) ? model_regs[cap_inst[3:0]]
                                        : {{8{cap_inst[7]}}, cap_inst[7:0]};
         known = 1'b1;
         wr    = 1'b1;
         arith = 1'b0;
         c     = 1'b0;
         v     = 1'b0;
         res   = '0;
         case (code)
            cpu_pkg::op_addi:
            begin
               wide  = {1'b0, a} + {1'b0, b};
               res   = wide[15:0];
               c     = wide[16];
               v     = (a[15] == b[15]) && (res[15] != a[15]);   // Like signs, new sign
               arith = 1'b1;
            end
            cpu_pkg::op_subi, cpu_pkg::op_cmpi:
            begin
               res   = a - b;
               c     = (a >= b);   // No borrow
               v     = (a[15] != b[15]) && (res[15] != a[15]);
               arith = 1'b1;
               wr    = (code == cpu_pkg::op_subi);   // Compare keeps Rdest
            end
            cpu_pkg::op_andi: res = a & b;
            cpu_pkg::op_ori:  res = a | b;
            cpu_pkg::op_xori: res = a ^ b;
            default:          known = 1'b0;   // Nothing defined to compare
         endcase
         if (known)
         begin
            compare("result", res, result);
            compare("flags", {12'h000, c, v, arith & res[15], res == 16'h0000}, flags);
            if (wr)
               model_regs[rd] = res;
         end
      end
   end

endmodule

// ==== verif/cpu_datapath_sva.sv ====
`timescale 1ns/1ps

module cpu_datapath_sva
(
   input logic             clk,
   input logic             reset,
   input logic             wr_en,
   input cpu_pkg::alu_op_t alu_op,
   input cpu_pkg::word_t   result,
   input cpu_pkg::flags_t  flags
);

   int   assert_fails = 0;   // Failed assertion count
   logic logical_op;

   assign logical_op = (alu_op == cpu_pkg::alu_and) ||
                       (alu_op == cpu_pkg::alu_or)  ||
                       (alu_op == cpu_pkg::alu_xor);

   // Instruction register still holds the reset word
   wr_low_after_reset: assert property (@(posedge clk) $fell(reset) |-> !wr_en)
   else
   begin
      assert_fails++;
      $error("write enable high right after reset");
   end

   logic_flags_clear: assert property (@(posedge clk) disable iff (reset)
                                       logical_op |-> (flags[3:1] == 3'b000))
   else
   begin
      assert_fails++;
      $error("carry, overflow or negative set by logical op");
   end

   zero_tracks_result: assert property (@(posedge clk) disable iff (reset)
                                        flags[0] == (result == '0))
   else
   begin
      assert_fails++;
      $error("zero flag disagrees with result");
   end

endmodule

// Watches decoder controls and ALU outputs of the datapath
bind cpu_datapath cpu_datapath_sva sva_i
(
   .clk    (clk),
   .reset  (reset),
   .wr_en  (dp_if.wr_en),
   .alu_op (dp_if.alu_op),
   .result (result),
   .flags  (flags)
);

// ==== verif/cpu_datapath_tb.sv ====
`timescale 1ns/1ps

module cpu_datapath_tb;

   localparam int n_imm   = 40;   // addi/subi
   localparam int n_rr    = 30;   // add/sub plus read back
   localparam int n_logic = 40;   // and/or/xor, both forms
   localparam int n_cmp   = 20;   // cmp plus read back
   localparam int n_unk   = 20;   // Undefined plus read back
   localparam int n_tests = 6;
   // Every instruction, one idle per test and the reset cycles
   localparam int total_instr = n_imm + 2*n_rr + n_logic + 2*n_cmp + 2*n_unk + n_tests + 4;
   localparam int timeout_ns  = (total_instr + 20) * 40;
   localparam cpu_pkg::word_t idle_inst = 16'h00f0;   // Reg form, undefined sub-op

   logic            clk;
   logic            reset;
   cpu_pkg::word_t  inst = '0;
   cpu_pkg::word_t  result;
   cpu_pkg::flags_t flags;
   int              checks;
   int              errors;
   int              base_checks;
   int              base_errors;
   int              tests_passed = 0;
   int              tests_failed = 0;

   tb_clock_gen clock_i (.clk(clk), .reset(reset));

   cpu_datapath dut_i (.clk(clk), .reset(reset), .inst(inst), .result(result), .flags(flags));

   cpu_checker checker_i
   (
      .clk(clk), .reset(reset), .inst(inst), .result(result), .flags(flags),
      .checks(checks), .errors(errors)
   );

   //////////////////////////////
   // Stimulus helpers
   //////////////////////////////

   task automatic issue(input cpu_pkg::word_t w);
      @(negedge clk);
      inst = w;
   endtask

   function automatic cpu_pkg::word_t imm_form(input cpu_pkg::opcode_t op,
                                               input cpu_pkg::reg_addr_t rd,
                                               input cpu_pkg::imm_t imm);
      return {op, rd, imm};
   endfunction

   function automatic cpu_pkg::word_t reg_form(input cpu_pkg::opcode_t sub,
                                               input cpu_pkg::reg_addr_t rd,
                                               input cpu_pkg::reg_addr_t rs);
      return {cpu_pkg::op_rr, rd, sub, rs};
   endfunction

   function automatic cpu_pkg::reg_addr_t pick_reg();
      return cpu_pkg::reg_addr_t'($urandom_range(15, 0));
   endfunction

   function automatic cpu_pkg::imm_t pick_imm();
      return cpu_pkg::imm_t'($urandom_range(255, 0));
   endfunction

   function automatic cpu_pkg::opcode_t pick_logic_op();
      case ($urandom_range(2, 0))
         0:       return cpu_pkg::op_andi;
         1:       return cpu_pkg::op_ori;
         default: return cpu_pkg::op_xori;
      endcase
   endfunction

   function automatic logic is_defined(input cpu_pkg::opcode_t c);
      return c inside {cpu_pkg::op_addi, cpu_pkg::op_subi, cpu_pkg::op_cmpi,
                       cpu_pkg::op_andi, cpu_pkg::op_ori, cpu_pkg::op_xori};
   endfunction

   // Major opcode 0000 is the register group, so never undefined
   function automatic cpu_pkg::opcode_t pick_undefined(input logic rr_form);
      cpu_pkg::opcode_t c;
      do
         c = cpu_pkg::opcode_t'($urandom_range(15, 0));
      while (is_defined(c) || (!rr_form && c == cpu_pkg::op_rr));
      return c;
   endfunction

   task automatic start_test(input string name);
      checker_i.test_name = name;
      base_checks         = checks;
      base_errors         = errors;
   endtask

   task automatic end_test();
      int new_checks;
      int new_errors;
      @(negedge clk);
      inst = idle_inst;   // Last real check lands on this edge
      #1;
      new_checks = checks - base_checks;
      new_errors = errors - base_errors;
      if (new_errors == 0 && new_checks > 0)
      begin
         tests_passed++;
         $display("test %s: ok, %0d checks", checker_i.test_name, new_checks);
      end
      else
      begin
         tests_failed++;
         if (new_checks == 0)
            $display("test %s: no checks ran", checker_i.test_name);
         else
            $display("test %s: %0d of %0d checks wrong", checker_i.test_name,
                     new_errors, new_checks);
      end
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   initial
   begin
      cpu_pkg::reg_addr_t rd;
      void'($urandom(32'h1b3c_4ef5));
      start_test("reset");
      @(negedge reset);
      end_test();

      start_test("imm_arith");   // Registers all start at zero
      repeat (n_imm)
         issue(imm_form(($urandom_range(1, 0) == 1) ? cpu_pkg::op_addi : cpu_pkg::op_subi,
                        pick_reg(), pick_imm()));
      end_test();

      start_test("rr_arith");
      repeat (n_rr)
      begin
         rd = pick_reg();
         issue(reg_form(($urandom_range(1, 0) == 1) ? cpu_pkg::op_addi : cpu_pkg::op_subi,
                        rd, pick_reg()));
         issue(imm_form(cpu_pkg::op_addi, rd, 8'h00));   // Sees the written value
      end
      end_test();

      start_test("logic");
      repeat (n_logic)
      begin
         if ($urandom_range(1, 0) == 1)
            issue(reg_form(pick_logic_op(), pick_reg(), pick_reg()));
         else
            issue(imm_form(pick_logic_op(), pick_reg(), pick_imm()));
      end
      end_test();

      start_test("compare");
      repeat (n_cmp)
      begin
         rd = pick_reg();
         if ($urandom_range(1, 0) == 1)
            issue(reg_form(cpu_pkg::op_cmpi, rd, pick_reg()));
         else
            issue(imm_form(cpu_pkg::op_cmpi, rd, pick_imm()));
         issue(imm_form(cpu_pkg::op_addi, rd, 8'h00));   // Rdest unchanged
      end
      end_test();

      start_test("undefined");
      repeat (n_unk)
      begin
         rd = pick_reg();
         if ($urandom_range(1, 0) == 1)
            issue(reg_form(pick_undefined(1'b1), rd, pick_reg()));
         else
            issue(imm_form(pick_undefined(1'b0), rd, pick_imm()));
         issue(imm_form(cpu_pkg::op_addi, rd, 8'h00));
      end
      end_test();

      $display("summary: %0d tests ok, %0d tests failed, %0d checks, %0d assertion failures",
               tests_passed, tests_failed, checks, dut_i.sva_i.assert_fails);
      if (tests_failed == 0 && dut_i.sva_i.assert_fails == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(timeout_ns);
      $display("Timeout: tests did not finish within %0d ns", timeout_ns);
      $display("Verification failed");
      $finish;
   end

endmodule

// ==== cpu_datapath.f ====
verilog/cpu_pkg.sv
verilog/datapath_if.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/carry_select_adder.sv
verilog/alu_unit.sv
verilog/cpu_datapath.sv
verif/tb_clock_gen.sv
verif/cpu_checker.sv
verif/cpu_datapath_sva.sv
verif/cpu_datapath_tb.sv

// ==== Makefile ====
TOP       ?= cpu_datapath_tb
FILELIST  ?= cpu_datapath.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUNARGS   ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUNARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
